// File: design/givens_settings.svh
`ifndef GIVENS_SETTINGS_SVH
`define GIVENS_SETTINGS_SVH

// sample format, signed two's complement
`define GV_WIDTH 14
`define GV_FRAC 10

// number of pipelined cordic micro-rotations
`define GV_ITER 8

// inverse cordic gain, about 0.6074 with GV_FRAC fraction bits
`define GV_GAIN 622
`define GV_GAIN_WIDTH 10

`endif

// File: design/givens_pkg.sv
`include "givens_settings.svh"

package givens_pkg;

    // every data value on the datapath
    typedef logic signed [`GV_WIDTH-1:0] sample_t;

    // sample times gain constant, full precision
    typedef logic signed [`GV_WIDTH+`GV_GAIN_WIDTH-1:0] product_t;

endpackage

// File: design/quadrant_fold.sv
`timescale 1ns/1ps

module quadrant_fold
    import givens_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    advance_i,
    input  logic    in_valid_i,
    input  sample_t a1_i,
    input  sample_t b1_i,
    input  sample_t a2_i,
    input  sample_t b2_i,
    output logic    valid_o,
    output sample_t lx_o,
    output sample_t ly_o,
    output sample_t fx_o,
    output sample_t fy_o
);

    logic flip;

    // leader in left half-plane, rotate both pairs by pi
    assign flip = (a1_i < 0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            if (flip) begin
                lx_o <= -a1_i;
                ly_o <= -b1_i;
                fx_o <= -a2_i;
                fy_o <= -b2_i;
            end else begin
                lx_o <= a1_i;
                ly_o <= b1_i;
                fx_o <= a2_i;
                fy_o <= b2_i;
            end
        end
    end

    // vectoring iterations converge only for x >= 0
    a_leader_right_half: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_o |-> (lx_o >= 0)
    );

endmodule

// File: design/givens_iteration.sv
`timescale 1ns/1ps

module givens_iteration
    import givens_pkg::*;
#(
    parameter int SHIFT = 0
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    advance_i,
    input  logic    valid_i,
    input  logic    rotated_i,
    input  sample_t lx_i,
    input  sample_t ly_i,
    input  sample_t fx_i,
    input  sample_t fy_i,
    output logic    valid_o,
    output logic    rotated_o,
    output sample_t lx_o,
    output sample_t ly_o,
    output sample_t fx_o,
    output sample_t fy_o
);

    logic    update;
    logic    dir_pos;
    sample_t lx_sh;
    sample_t ly_sh;
    sample_t fx_sh;
    sample_t fy_sh;
    sample_t lx_nxt;
    sample_t ly_nxt;
    sample_t fx_nxt;
    sample_t fy_nxt;

    // leader already on the x axis so nothing to do
    assign update  = (ly_i != 0);
    assign dir_pos = (ly_i > 0);

    assign lx_sh = lx_i >>> SHIFT;
    assign ly_sh = ly_i >>> SHIFT;
    assign fx_sh = fx_i >>> SHIFT;
    assign fy_sh = fy_i >>> SHIFT;

    // same micro-rotation on leader and follower
    always_comb begin
        if (!update) begin
            lx_nxt = lx_i;
            ly_nxt = ly_i;
            fx_nxt = fx_i;
            fy_nxt = fy_i;
        end else if (dir_pos) begin
            lx_nxt = lx_i + ly_sh;
            ly_nxt = ly_i - lx_sh;
            fx_nxt = fx_i + fy_sh;
            fy_nxt = fy_i - fx_sh;
        end else begin
            lx_nxt = lx_i - ly_sh;
            ly_nxt = ly_i + lx_sh;
            fx_nxt = fx_i - fy_sh;
            fy_nxt = fy_i + fx_sh;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o   <= 1'b0;
            rotated_o <= 1'b0;
        end else if (advance_i) begin
            valid_o   <= valid_i;
            rotated_o <= rotated_i | update;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            lx_o <= lx_nxt;
            ly_o <= ly_nxt;
            fx_o <= fx_nxt;
            fy_o <= fy_nxt;
        end
    end

    // upstream stage holds its slot and payload on a stall
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        !advance_i |=> $stable(valid_i) && $stable(rotated_i)
                       && (!valid_i || $stable({lx_i, ly_i, fx_i, fy_i}))
    );

endmodule

// File: design/gain_compensate.sv
`timescale 1ns/1ps
`include "givens_settings.svh"

module gain_compensate
    import givens_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    out_ready_i,
    input  logic    valid_i,
    input  logic    rotated_i,
    input  sample_t lx_i,
    input  sample_t fx_i,
    input  sample_t fy_i,
    output logic    advance_o,
    output logic    out_valid_o,
    output sample_t r11_o,
    output sample_t r12_o,
    output sample_t r22_o
);

    localparam product_t GAIN = product_t'(`GV_GAIN);

    sample_t r11_nxt;
    sample_t r12_nxt;
    sample_t r22_nxt;

    // undo cordic growth only if some iteration rotated
    function automatic sample_t compensate(input sample_t v, input logic en);
        product_t prod;
        prod = product_t'(v) * GAIN;
        if (en) begin
            return prod[`GV_FRAC +: `GV_WIDTH];
        end
        return v;
    endfunction

    assign r11_nxt = compensate(lx_i, rotated_i);
    assign r12_nxt = compensate(fx_i, rotated_i);
    assign r22_nxt = compensate(fy_i, rotated_i);

    // whole pipeline moves when the output slot frees up
    assign advance_o = !out_valid_o || out_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
        end else if (advance_o) begin
            out_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) begin
            r11_o <= r11_nxt;
            r12_o <= r12_nxt;
            r22_o <= r22_nxt;
        end
    end

    // stage behind the output keeps its result until the sink takes one
    a_stable_when_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid_o && !out_ready_i |=> $stable(valid_i)
            && (!valid_i || $stable({rotated_i, lx_i, fx_i, fy_i}))
    );

endmodule

// File: design/givens_top.sv
`timescale 1ns/1ps
`include "givens_settings.svh"

module givens_top
    import givens_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid_i,
    input  logic    out_ready_i,
    input  sample_t a1_i,
    input  sample_t b1_i,
    input  sample_t a2_i,
    input  sample_t b2_i,
    output logic    in_ready_o,
    output logic    out_valid_o,
    output sample_t r11_o,
    output sample_t r12_o,
    output sample_t r22_o
);

    logic    advance;

    // index 0 is the fold output, index GV_ITER the last iteration
    logic    valid_s   [0:`GV_ITER];
    logic    rotated_s [0:`GV_ITER];
    sample_t lx_s      [0:`GV_ITER];
    sample_t ly_s      [0:`GV_ITER-1];
    sample_t fx_s      [0:`GV_ITER];
    sample_t fy_s      [0:`GV_ITER];

    assign in_ready_o   = advance;
    assign rotated_s[0] = 1'b0;

    quadrant_fold u_fold (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance_i  (advance),
        .in_valid_i (in_valid_i),
        .a1_i       (a1_i),
        .b1_i       (b1_i),
        .a2_i       (a2_i),
        .b2_i       (b2_i),
        .valid_o    (valid_s[0]),
        .lx_o       (lx_s[0]),
        .ly_o       (ly_s[0]),
        .fx_o       (fx_s[0]),
        .fy_o       (fy_s[0])
    );

    genvar k;
    generate
        for (k = 0; k < `GV_ITER - 1; k++) begin : g_iter
            givens_iteration #(.SHIFT(k)) u_iter (
                .clk       (clk),
                .rst_n     (rst_n),
                .advance_i (advance),
                .valid_i   (valid_s[k]),
                .rotated_i (rotated_s[k]),
                .lx_i      (lx_s[k]),
                .ly_i      (ly_s[k]),
                .fx_i      (fx_s[k]),
                .fy_i      (fy_s[k]),
                .valid_o   (valid_s[k+1]),
                .rotated_o (rotated_s[k+1]),
                .lx_o      (lx_s[k+1]),
                .ly_o      (ly_s[k+1]),
                .fx_o      (fx_s[k+1]),
                .fy_o      (fy_s[k+1])
            );
        end
    endgenerate

    // residual leader y is r21, zero by construction
    givens_iteration #(.SHIFT(`GV_ITER - 1)) u_iter_last (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance_i (advance),
        .valid_i   (valid_s[`GV_ITER-1]),
        .rotated_i (rotated_s[`GV_ITER-1]),
        .lx_i      (lx_s[`GV_ITER-1]),
        .ly_i      (ly_s[`GV_ITER-1]),
        .fx_i      (fx_s[`GV_ITER-1]),
        .fy_i      (fy_s[`GV_ITER-1]),
        .valid_o   (valid_s[`GV_ITER]),
        .rotated_o (rotated_s[`GV_ITER]),
        .lx_o      (lx_s[`GV_ITER]),
        .ly_o      (),
        .fx_o      (fx_s[`GV_ITER]),
        .fy_o      (fy_s[`GV_ITER])
    );

    gain_compensate u_gain (
        .clk         (clk),
        .rst_n       (rst_n),
        .out_ready_i (out_ready_i),
        .valid_i     (valid_s[`GV_ITER]),
        .rotated_i   (rotated_s[`GV_ITER]),
        .lx_i        (lx_s[`GV_ITER]),
        .fx_i        (fx_s[`GV_ITER]),
        .fy_i        (fy_s[`GV_ITER]),
        .advance_o   (advance),
        .out_valid_o (out_valid_o),
        .r11_o       (r11_o),
        .r12_o       (r12_o),
        .r22_o       (r22_o)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk_o
);

    // 4 ns period, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

endmodule

// File: test/givens_tb.sv
`timescale 1ns/1ps

module givens_tb
    import givens_pkg::*;
();

    localparam logic [31:0] SEED_VALUE = 32'h06c2e8ec;
    localparam int N_AXIS       = 6;
    localparam int N_RANDOM     = 64;
    localparam int N_NEGATIVE   = 12;
    localparam int N_STALL      = 48;
    localparam int N_TXN        = N_AXIS + N_RANDOM + N_NEGATIVE + N_STALL + 1;
    localparam int WATCHDOG_NS  = (N_TXN + 40) * 12 * 4;
    localparam int LATENCY      = 10;
    localparam int ACCEPT_LIMIT = 100;
    localparam int DRAIN_LIMIT  = 400;

    logic    clk;
    logic    rst_n;
    logic    in_valid_i;
    logic    out_ready_i;
    logic    in_ready_o;
    logic    out_valid_o;
    sample_t a1_i;
    sample_t b1_i;
    sample_t a2_i;
    sample_t b2_i;
    sample_t r11_o;
    sample_t r12_o;
    sample_t r22_o;

    int   checks       = 0;
    int   errors       = 0;
    int   accepted     = 0;
    int   results      = 0;
    int   stall_events = 0;
    logic stall_mode   = 1'b0;
    logic stalled      = 1'b0;
    int   held_r11;
    int   held_r12;
    int   held_r22;

    // transactions accepted but not yet seen on the output
    int    q_a1 [$];
    int    q_b1 [$];
    int    q_a2 [$];
    int    q_b2 [$];
    string q_name [$];

    // leader on the x axis, b1 is zero for all of these
    int axis_a1 [N_AXIS] = '{1024, -1024, 2048, -1, -2048, 513};
    int axis_a2 [N_AXIS] = '{300, 300, -2048, 7, 1234, 0};
    int axis_b2 [N_AXIS] = '{-500, -500, 2048, -7, -99, 0};

    tb_clock u_clock (
        .clk_o (clk)
    );

    givens_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .out_ready_i (out_ready_i),
        .a1_i        (a1_i),
        .b1_i        (b1_i),
        .a2_i        (a2_i),
        .b2_i        (b2_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .r11_o       (r11_o),
        .r12_o       (r12_o),
        .r22_o       (r22_o)
    );

    function automatic int magnitude(input int v);
        return (v < 0) ? -v : v;
    endfunction

    function automatic int largest_of(input int a, input int b, input int c, input int d);
        int m;
        m = magnitude(a);
        if (magnitude(b) > m) begin
            m = magnitude(b);
        end
        if (magnitude(c) > m) begin
            m = magnitude(c);
        end
        if (magnitude(d) > m) begin
            m = magnitude(d);
        end
        return m;
    endfunction

    // uniform in [-2.0, 2.0] with 10 fraction bits
    function automatic int random_sample();
        return int'($urandom_range(4096)) - 2048;
    endfunction

    task automatic compare_exact(input string name, input string field,
                                 input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     name, field, expected, actual);
        end
    endtask

    task automatic tolerance_check(input string name, input string field,
                                   input real expected, input int actual, input real tol);
        real diff;
        diff = real'(actual) - expected;
        if (diff < 0.0) begin
            diff = -diff;
        end
        checks++;
        assert (diff <= tol) else begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0.2f (tolerance %0.2f), actual %0d",
                     name, field, expected, tol, actual);
        end
    endtask

    task automatic score_result;
        int    a1;
        int    b1;
        int    a2;
        int    b2;
        int    polarity;
        string name;
        real   r;
        real   tol;
        if (q_name.size() == 0) begin
            errors++;
            $display("ERROR: result on the output with no transaction pending");
        end else begin
            name = q_name.pop_front();
            a1   = q_a1.pop_front();
            b1   = q_b1.pop_front();
            a2   = q_a2.pop_front();
            b2   = q_b2.pop_front();
            results++;
            if (b1 == 0) begin
                // no rotation and no gain, fold only
                polarity = (a1 < 0) ? -1 : 1;
                compare_exact(name, "r11", polarity * a1, int'(r11_o));
                compare_exact(name, "r12", polarity * a2, int'(r12_o));
                compare_exact(name, "r22", polarity * b2, int'(r22_o));
            end else begin
                r   = $sqrt(real'(a1 * a1 + b1 * b1));
                tol = 4.0 + real'(largest_of(a1, b1, a2, b2)) / 64.0;
                tolerance_check(name, "r11", r, int'(r11_o), tol);
                tolerance_check(name, "r12", real'(a1 * a2 + b1 * b2) / r, int'(r12_o), tol);
                tolerance_check(name, "r22", real'(a1 * b2 - b1 * a2) / r, int'(r22_o), tol);
            end
            checks++;
            assert (r11_o >= 0) else begin
                errors++;
                $display("CHECK FAILED %s r11: expected >= 0, actual %0d", name, int'(r11_o));
            end
        end
    endtask

    task automatic stall_hold_check;
        checks++;
        assert (out_valid_o) else begin
            errors++;
            $display("ERROR: out_valid_o dropped while a result was stalled");
        end
        compare_exact("back_pressure", "held r11", held_r11, int'(r11_o));
        compare_exact("back_pressure", "held r12", held_r12, int'(r12_o));
        compare_exact("back_pressure", "held r22", held_r22, int'(r22_o));
    endtask

    task automatic send_txn(input string name, input int a1, input int b1,
                            input int a2, input int b2);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        @(negedge clk);
        in_valid_i = 1'b1;
        a1_i       = sample_t'(a1);
        b1_i       = sample_t'(b1);
        a2_i       = sample_t'(a2);
        b2_i       = sample_t'(b2);
        while (!taken && waited < ACCEPT_LIMIT) begin
            @(posedge clk);
            waited++;
            taken = in_ready_o;
        end
        if (taken) begin
            q_name.push_back(name);
            q_a1.push_back(a1);
            q_b1.push_back(b1);
            q_a2.push_back(a2);
            q_b2.push_back(b2);
            accepted++;
        end else begin
            errors++;
            $display("ERROR: %s transaction not accepted within %0d cycles", name, ACCEPT_LIMIT);
        end
    endtask

    task automatic stop_input;
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    task automatic drain_pipeline;
        int waited;
        waited = 0;
        stop_input();
        while (q_name.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (q_name.size() != 0) begin
            errors++;
            $display("ERROR: %0d results never left the pipeline", q_name.size());
            q_name.delete();
            q_a1.delete();
            q_b1.delete();
            q_a2.delete();
            q_b2.delete();
        end
    endtask

    task automatic reset_state;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        compare_exact("reset", "out_valid_o", 0, int'(out_valid_o));
        compare_exact("reset", "in_ready_o", 1, int'(in_ready_o));
    endtask

    task automatic axis_leader;
        for (int i = 0; i < N_AXIS; i++) begin
            send_txn("axis_leader", axis_a1[i], 0, axis_a2[i], axis_b2[i]);
        end
        drain_pipeline();
    endtask

    task automatic random_stream;
        for (int i = 0; i < N_RANDOM; i++) begin
            send_txn("random_stream", random_sample(), random_sample(),
                     random_sample(), random_sample());
        end
        drain_pipeline();
    endtask

    task automatic negative_leader;
        for (int i = 0; i < N_NEGATIVE; i++) begin
            send_txn("negative_leader", -1 - int'($urandom_range(2047)), random_sample(),
                     random_sample(), random_sample());
        end
        drain_pipeline();
    endtask

    task automatic back_pressure;
        stall_mode = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            send_txn("back_pressure", random_sample(), random_sample(),
                     random_sample(), random_sample());
        end
        drain_pipeline();
        stall_mode = 1'b0;
        checks++;
        assert (stall_events > 0) else begin
            errors++;
            $display("ERROR: back_pressure test never stalled a result");
        end
    endtask

    task automatic latency_single;
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        send_txn("latency", 700, -300, -1200, 450);
        stop_input();
        // the accepting edge was edge 0
        while (!seen && edges < 4 * LATENCY) begin
            @(posedge clk);
            edges++;
            seen = out_valid_o;
        end
        if (!seen) begin
            errors++;
            $display("ERROR: latency test saw no result within %0d cycles", 4 * LATENCY);
        end else begin
            compare_exact("latency", "edges", LATENCY, edges);
        end
        drain_pipeline();
    endtask

    task automatic finish_report;
        $display("checks %0d, errors %0d, results %0d of %0d accepted",
                 checks, errors, results, accepted);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
    endtask

    // sink side, random stalls only inside the back-pressure test
    initial begin
        out_ready_i = 1'b1;
        forever begin
            @(negedge clk);
            if (stall_mode) begin
                out_ready_i = ($urandom_range(2) != 0);
            end else begin
                out_ready_i = 1'b1;
            end
        end
    end

    // output monitor, values seen here are the ones before the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (stalled) begin
                stall_hold_check();
            end
            if (out_valid_o && out_ready_i) begin
                score_result();
            end
            stalled  = out_valid_o && !out_ready_i;
            held_r11 = int'(r11_o);
            held_r12 = int'(r12_o);
            held_r22 = int'(r22_o);
            if (stalled) begin
                stall_events++;
            end
        end else begin
            stalled = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        errors++;
        $display("ERROR: watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        finish_report();
        $finish;
    end

    initial begin
        void'($urandom(SEED_VALUE));
        rst_n      = 1'b0;
        in_valid_i = 1'b0;
        a1_i       = '0;
        b1_i       = '0;
        a2_i       = '0;
        b2_i       = '0;
        reset_state();
        axis_leader();
        random_stream();
        negative_leader();
        back_pressure();
        latency_single();
        compare_exact("summary", "results", accepted, results);
        finish_report();
        $finish;
    end

endmodule

// File: files.f
+incdir+design
design/givens_pkg.sv
design/quadrant_fold.sv
design/givens_iteration.sv
design/gain_compensate.sv
design/givens_top.sv
test/tb_clock.sv
test/givens_tb.sv

// File: run.sh
#!/bin/sh
# build the givens rotation testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module givens_tb -f files.f -o givens_sim \
    || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/givens_sim 2>&1)
echo "$out"
echo "$out" | grep -q "^Simulation passed$" && exit 0 || exit 1
